/* src/runaheadPkg.sv */
package runaheadPkg;

    localparam int numRegs = 16;
    localparam int regAddrW = 4;
    localparam int instrW = 16;
    localparam int opcodeW = 4;

    typedef logic [regAddrW-1:0] regAddrT;
    typedef logic [instrW-1:0] instrT;
    typedef logic [opcodeW-1:0] opcodeT;

    // Field positions, each field is regAddrW or opcodeW bits wide
    localparam int opcodeLsb = 12;
    localparam int destLsb = 8;
    localparam int srcALsb = 4;
    localparam int srcBLsb = 0;

    // Status of one register, dirty is the MSB
    typedef struct packed {
        logic dirty;
        logic toBeWritten;
        logic toBeRead;
    } statusVecT;

    // Load writeback or load miss
    typedef struct packed {
        logic valid;
        regAddrT dest;
    } loadEventT;

    // fwd0 is the previous issued instruction, fwd1 the one before it
    typedef struct packed {
        logic fwd0ToA;
        logic fwd1ToA;
        logic fwd0ToB;
        logic fwd1ToB;
    } forwardFlagsT;

    typedef struct packed {
        logic valid;
        instrT instr;
    } queueEntryT;

endpackage : runaheadPkg

/* src/registerStatusTable.sv */
`timescale 1ns/1ps

module registerStatusTable (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  clkEn,
    input  logic                  issueValid,
    input  runaheadPkg::instrT    issueInstr,
    input  logic                  divert,
    input  runaheadPkg::loadEventT loadWb,
    input  runaheadPkg::loadEventT loadMiss,
    input  logic                  queueDrained,
    output runaheadPkg::statusVecT statusA,
    output runaheadPkg::statusVecT statusB
);

    import runaheadPkg::*;

    statusVecT statusTable [numRegs];
    statusVecT nextTable [numRegs];

    regAddrT destReg;
    regAddrT srcA;
    regAddrT srcB;

    assign destReg = issueInstr[destLsb +: regAddrW];
    assign srcA = issueInstr[srcALsb +: regAddrW];
    assign srcB = issueInstr[srcBLsb +: regAddrW];

    // Operand status read out in the issue cycle
    assign statusA = statusTable[srcA];
    assign statusB = statusTable[srcB];

    // Later rules override earlier ones on the same register
    always_comb begin
        nextTable = statusTable;

        if (loadWb.valid) begin
            nextTable[loadWb.dest].dirty = 1'b0;
            nextTable[loadWb.dest].toBeWritten = 1'b0;
        end

        if (loadMiss.valid) begin
            nextTable[loadMiss.dest].dirty = 1'b1;
        end

        if (issueValid && !divert) begin
            nextTable[destReg].toBeWritten = 1'b1;
        end

        // Diverted result is poisoned and will not be written
        if (divert) begin
            nextTable[destReg].dirty = 1'b1;
            nextTable[srcA].toBeRead = 1'b1;
            nextTable[destReg].toBeWritten = 1'b0;
        end

        // Queue emptied, nothing is waiting to read anymore
        if (queueDrained) begin
            for (int i = 0; i < numRegs; i++) begin
                nextTable[i].toBeRead = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            statusTable <= '{default: '0};
        end else if (clkEn) begin
            statusTable <= nextTable;
        end
    end

    // Writeback and miss of the same register would leave dirty ambiguous
    assert property (@(posedge clk) disable iff (!arstN)
        !(loadWb.valid && loadMiss.valid && loadWb.dest == loadMiss.dest))
        else $error("loadWb and loadMiss target the same register");

endmodule : registerStatusTable

/* src/forwardDetect.sv */
`timescale 1ns/1ps

module forwardDetect (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     clkEn,
    input  logic                     issueValid,
    input  runaheadPkg::instrT       issueInstr,
    output runaheadPkg::forwardFlagsT fwdFlags
);

    import runaheadPkg::*;

    regAddrT destReg;
    regAddrT srcA;
    regAddrT srcB;

    // Slot 0 is the previous issue, slot 1 the one before
    logic [1:0] histValid;
    regAddrT histDest [2];

    assign destReg = issueInstr[destLsb +: regAddrW];
    assign srcA = issueInstr[srcALsb +: regAddrW];
    assign srcB = issueInstr[srcBLsb +: regAddrW];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            histValid <= '0;
        end else if (clkEn && issueValid) begin
            histValid <= {histValid[0], 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (clkEn && issueValid) begin
            histDest[1] <= histDest[0];
            histDest[0] <= destReg;
        end
    end

    // Empty slots never match
    always_comb begin
        fwdFlags.fwd0ToA = histValid[0] && (histDest[0] == srcA);
        fwdFlags.fwd1ToA = histValid[1] && (histDest[1] == srcA);
        fwdFlags.fwd0ToB = histValid[0] && (histDest[0] == srcB);
        fwdFlags.fwd1ToB = histValid[1] && (histDest[1] == srcB);
    end

endmodule : forwardDetect

/* src/operandValidation.sv */
`timescale 1ns/1ps

module operandValidation (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      clkEn,
    input  logic                      issueValid,
    input  runaheadPkg::instrT        issueInstr,
    input  runaheadPkg::statusVecT    statusA,
    input  runaheadPkg::statusVecT    statusB,
    input  runaheadPkg::forwardFlagsT fwdFlags,
    input  runaheadPkg::loadEventT    loadWb,
    output logic                      divert,
    output logic                      forwardLoadToA,
    output logic                      forwardLoadToB
);

    import runaheadPkg::*;

    regAddrT srcA;
    regAddrT srcB;

    // Bit 0 is the previous issue slot, bit 1 two back
    logic [1:0] runaheadHistory;

    logic loadMatchA;
    logic loadMatchB;
    logic dirtyA;
    logic dirtyB;
    logic toBeReadA;
    logic poisonFwdA;
    logic poisonFwdB;

    assign srcA = issueInstr[srcALsb +: regAddrW];
    assign srcB = issueInstr[srcBLsb +: regAddrW];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            runaheadHistory <= '0;
        end else if (clkEn) begin
            runaheadHistory <= {runaheadHistory[0], divert};
        end
    end

    // Operand fed by a diverted producer through forwarding
    assign poisonFwdA = (fwdFlags.fwd0ToA && runaheadHistory[0]) ||
                        (fwdFlags.fwd1ToA && runaheadHistory[1]);
    assign poisonFwdB = (fwdFlags.fwd0ToB && runaheadHistory[0]) ||
                        (fwdFlags.fwd1ToB && runaheadHistory[1]);

    // Completing load supplies the operand this cycle
    assign loadMatchA = loadWb.valid && (loadWb.dest == srcA);
    assign loadMatchB = loadWb.valid && (loadWb.dest == srcB);

    assign dirtyA = statusA.dirty && !loadMatchA;
    assign dirtyB = statusB.dirty && !loadMatchB;
    assign toBeReadA = statusA.toBeRead;

    assign divert = issueValid &&
                    (dirtyA || dirtyB || toBeReadA || poisonFwdA || poisonFwdB);

    assign forwardLoadToA = loadMatchA;
    assign forwardLoadToB = loadMatchB;

    // Unknown status or history would push and poison at random
    assert property (@(posedge clk) disable iff (!arstN) !$isunknown(divert))
        else $error("divert is unknown");

endmodule : operandValidation

/* src/runaheadQueue.sv */
`timescale 1ns/1ps

module runaheadQueue #(
    parameter int queueDepth = 8
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    push,
    input  runaheadPkg::instrT      pushInstr,
    input  logic                    pop,
    output runaheadPkg::queueEntryT head,
    output logic                    full,
    output logic                    queueDrained
);

    import runaheadPkg::*;

    localparam int ptrW = (queueDepth > 1) ? $clog2(queueDepth) : 1;

    typedef logic [ptrW-1:0] ptrT;
    typedef logic [ptrW:0] countT;

    localparam ptrT lastIdx = ptrT'(queueDepth - 1);
    localparam countT depthCount = countT'(queueDepth);

    instrT mem [queueDepth];
    ptrT wrPtr;
    ptrT rdPtr;
    countT count;

    logic empty;
    logic doPop;

    assign empty = (count == '0);
    assign full = (count == depthCount);

    // A pop on an empty queue is dropped
    assign doPop = pop && !empty;

    // Last entry leaves and nothing arrives behind it
    assign queueDrained = doPop && !push && (count == countT'(1));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == lastIdx) ? '0 : wrPtr + ptrT'(1);
            end
            if (doPop) begin
                rdPtr <= (rdPtr == lastIdx) ? '0 : rdPtr + ptrT'(1);
            end
            if (push && !doPop) begin
                count <= count + countT'(1);
            end else if (!push && doPop) begin
                count <= count - countT'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushInstr;
        end
    end

    always_comb begin
        head.valid = !empty;
        head.instr = empty ? '0 : mem[rdPtr];
    end

    // Issuer holds off on full, so no push may be lost
    assert property (@(posedge clk) disable iff (!arstN) !(push && full))
        else $error("push into a full runahead queue");

endmodule : runaheadQueue

/* src/runaheadIssue.sv */
`timescale 1ns/1ps

module runaheadIssue #(
    parameter int queueDepth = 8
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    clkEn,
    input  logic                    issueValid,
    input  runaheadPkg::instrT      issueInstr,
    input  runaheadPkg::loadEventT  loadWb,
    input  runaheadPkg::loadEventT  loadMiss,
    input  logic                    replayPop,
    output logic                    invalidateIssued,
    output logic                    forwardLoadToA,
    output logic                    forwardLoadToB,
    output runaheadPkg::queueEntryT queueHead,
    output logic                    queueFull
);

    import runaheadPkg::*;

    statusVecT statusA;
    statusVecT statusB;
    forwardFlagsT fwdFlags;
    logic divert;
    logic queueDrained;

    // Diverted instruction is the one invalidated at issue
    assign invalidateIssued = divert;

    registerStatusTable uStatusTable (
        .clk          (clk),
        .arstN        (arstN),
        .clkEn        (clkEn),
        .issueValid   (issueValid),
        .issueInstr   (issueInstr),
        .divert       (divert),
        .loadWb       (loadWb),
        .loadMiss     (loadMiss),
        .queueDrained (queueDrained),
        .statusA      (statusA),
        .statusB      (statusB)
    );

    forwardDetect uForwardDetect (
        .clk        (clk),
        .arstN      (arstN),
        .clkEn      (clkEn),
        .issueValid (issueValid),
        .issueInstr (issueInstr),
        .fwdFlags   (fwdFlags)
    );

    operandValidation uOperandValidation (
        .clk            (clk),
        .arstN          (arstN),
        .clkEn          (clkEn),
        .issueValid     (issueValid),
        .issueInstr     (issueInstr),
        .statusA        (statusA),
        .statusB        (statusB),
        .fwdFlags       (fwdFlags),
        .loadWb         (loadWb),
        .divert         (divert),
        .forwardLoadToA (forwardLoadToA),
        .forwardLoadToB (forwardLoadToB)
    );

    runaheadQueue #(
        .queueDepth (queueDepth)
    ) uRunaheadQueue (
        .clk          (clk),
        .arstN        (arstN),
        .push         (divert),
        .pushInstr    (issueInstr),
        .pop          (replayPop),
        .head         (queueHead),
        .full         (queueFull),
        .queueDrained (queueDrained)
    );

endmodule : runaheadIssue

/* sim/runaheadIssueModel.svh */
`ifndef RUNAHEAD_ISSUE_MODEL_SVH
`define RUNAHEAD_ISSUE_MODEL_SVH

// Expected register status, issue histories and queue contents
statusVecT modelStatus [numRegs];
logic [1:0] modelRunHist;
logic [1:0] modelDestValid;
regAddrT modelDestHist [2];
instrT modelQueue [$];

function automatic regAddrT fieldOf(input instrT instr, input int lsb);
    return instr[lsb +: regAddrW];
endfunction

function automatic logic modelForward(input instrT instr, input loadEventT wb, input int lsb);
    return wb.valid && (wb.dest == fieldOf(instr, lsb));
endfunction

function automatic logic modelDivert(input logic valid, input instrT instr, input loadEventT wb);
    regAddrT a;
    regAddrT b;
    logic poison;
    a = fieldOf(instr, srcALsb);
    b = fieldOf(instr, srcBLsb);
    poison = (modelStatus[a].dirty && !modelForward(instr, wb, srcALsb)) ||
             (modelStatus[b].dirty && !modelForward(instr, wb, srcBLsb)) ||
             modelStatus[a].toBeRead;
    // Slot s is the producer s + 1 issues back
    for (int s = 0; s < 2; s++) begin
        if (modelDestValid[s] && modelRunHist[s] &&
            (modelDestHist[s] == a || modelDestHist[s] == b)) begin
            poison = 1'b1;
        end
    end
    return valid && poison;
endfunction

task automatic modelStep(input logic en, input logic valid, input instrT instr,
                         input loadEventT wb, input loadEventT miss, input logic pop);
    logic dv;
    logic popped;
    regAddrT d;
    dv = modelDivert(valid, instr, wb);
    d = fieldOf(instr, destLsb);
    popped = pop && (modelQueue.size() > 0);
    if (en) begin
        if (wb.valid) begin
            modelStatus[wb.dest].dirty = 1'b0;
            modelStatus[wb.dest].toBeWritten = 1'b0;
        end
        if (miss.valid) modelStatus[miss.dest].dirty = 1'b1;
        if (valid && !dv) modelStatus[d].toBeWritten = 1'b1;
        if (dv) begin
            modelStatus[d].dirty = 1'b1;
            modelStatus[fieldOf(instr, srcALsb)].toBeRead = 1'b1;
            modelStatus[d].toBeWritten = 1'b0;
        end
        // Last entry leaves with nothing pushed behind it
        if (popped && !dv && modelQueue.size() == 1) begin
            foreach (modelStatus[i]) modelStatus[i].toBeRead = 1'b0;
        end
        modelRunHist = {modelRunHist[0], dv};
        if (valid) begin
            modelDestHist[1] = modelDestHist[0];
            modelDestHist[0] = d;
            modelDestValid = {modelDestValid[0], 1'b1};
        end
    end
    // Queue moves whether or not issue is enabled
    if (popped) void'(modelQueue.pop_front());
    if (dv) modelQueue.push_back(instr);
endtask

task automatic modelReset();
    foreach (modelStatus[i]) modelStatus[i] = '0;
    modelRunHist = '0;
    modelDestValid = '0;
    modelDestHist[0] = '0;
    modelDestHist[1] = '0;
    modelQueue.delete();
endtask

function automatic queueEntryT modelHead();
    queueEntryT entry;
    entry = '0;
    if (modelQueue.size() > 0) begin
        entry.valid = 1'b1;
        entry.instr = modelQueue[0];
    end
    return entry;
endfunction

`endif

/* sim/runaheadIssueTb.sv */
`timescale 1ns/1ps

module runaheadIssueTb;

    import runaheadPkg::*;

    localparam int queueDepth = 8;
    localparam int clkPeriod = 40;
    localparam int driveDelay = 5;
    localparam int resetCycles = 16;
    localparam int shortLen = 400;
    localparam int longLen = 600;
    localparam int timeoutLimit = resetCycles + 5 * shortLen + longLen + 100;

    logic clk;
    logic arstN;
    logic clkEn;
    logic issueValid;
    instrT issueInstr;
    loadEventT loadWb;
    loadEventT loadMiss;
    logic replayPop;
    logic invalidateIssued;
    logic forwardLoadToA;
    logic forwardLoadToB;
    logic queueFull;
    queueEntryT queueHead;

    string testName;
    int testErrors;
    int errorCount;
    int passedTests;
    int failedTests;
    int divertCount;
    int cycleCount;

    `include "runaheadIssueModel.svh"

    runaheadIssue #(.queueDepth(queueDepth)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", timeoutLimit);
        $display("Testbench failed");
        $finish;
    end

    task automatic checkFlag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error %s %s: expected %0b actual %0b", testName, what, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkEntry(input string what, input queueEntryT expected,
                              input queueEntryT actual);
        if (actual !== expected) begin
            $display("error %s %s: expected %h actual %h", testName, what, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkInstr(input string what, input instrT expected, input instrT actual);
        if (actual !== expected) begin
            $display("error %s %s: expected %h actual %h", testName, what, expected, actual);
            testErrors++;
        end
    endtask

    function automatic regAddrT randomReg(input int span);
        return regAddrT'($urandom_range(span - 1, 0));
    endfunction

    // Knobs are percentages, regSpan narrows registers to force collisions
    task automatic runTest(input string name, input int cycles, input int pIssue,
                           input int pMiss, input int pWb, input int pPop, input int pEn,
                           input int regSpan);
        logic expDivert;
        logic headPending;
        instrT pendingInstr;
        testName = name;
        testErrors = 0;
        divertCount = 0;
        headPending = 1'b0;
        pendingInstr = '0;
        repeat (cycles) begin
            @(posedge clk);
            #driveDelay;
            clkEn = ($urandom_range(99, 0) < pEn);
            issueValid = ($urandom_range(99, 0) < pIssue) && (modelQueue.size() < queueDepth);
            issueInstr = {opcodeT'($urandom()), randomReg(regSpan), randomReg(regSpan),
                          randomReg(regSpan)};
            loadWb.valid = ($urandom_range(99, 0) < pWb);
            loadWb.dest = randomReg(regSpan);
            loadMiss.valid = ($urandom_range(99, 0) < pMiss);
            loadMiss.dest = randomReg(regSpan);
            if (loadMiss.dest == loadWb.dest) loadMiss.valid = 1'b0;
            replayPop = ($urandom_range(99, 0) < pPop);
            @(negedge clk);
            expDivert = modelDivert(issueValid, issueInstr, loadWb);
            checkFlag("invalidateIssued", expDivert, invalidateIssued);
            checkFlag("forwardLoadToA", modelForward(issueInstr, loadWb, srcALsb), forwardLoadToA);
            checkFlag("forwardLoadToB", modelForward(issueInstr, loadWb, srcBLsb), forwardLoadToB);
            checkFlag("queueFull", modelQueue.size() == queueDepth, queueFull);
            checkEntry("queueHead", modelHead(), queueHead);
            if (headPending) begin
                checkInstr("diverted instruction at head", pendingInstr, queueHead.instr);
            end
            if (expDivert) divertCount++;
            modelStep(clkEn, issueValid, issueInstr, loadWb, loadMiss, replayPop);
            // Sole entry after the push, so it is the head one cycle later
            headPending = expDivert && (modelQueue.size() == 1);
            pendingInstr = issueInstr;
        end
        $display("%s: %0d cycles, %0d diverted, %0d errors", name, cycles, divertCount,
                 testErrors);
        if (testErrors == 0) passedTests++;
        else failedTests++;
        errorCount += testErrors;
    endtask

    initial begin
        void'($urandom(32'h63953c1a));
        arstN = 1'b0;
        clkEn = 1'b0;
        issueValid = 1'b0;
        issueInstr = '0;
        loadWb = '0;
        loadMiss = '0;
        replayPop = 1'b0;
        errorCount = 0;
        passedTests = 0;
        failedTests = 0;
        modelReset();
        repeat (resetCycles) @(posedge clk);
        #driveDelay;
        arstN = 1'b1;
        runTest("dirtyOperand", shortLen, 70, 30, 5, 20, 100, 4);
        runTest("loadMask", shortLen, 70, 25, 50, 20, 100, 4);
        runTest("forwardPoison", shortLen, 90, 10, 10, 30, 100, 3);
        runTest("clockEnable", shortLen, 60, 20, 20, 25, 40, 4);
        runTest("queueOrderFull", longLen, 80, 30, 5, 15, 100, 4);
        runTest("drain", shortLen, 30, 5, 40, 70, 100, 4);
        $display("Tests: %0d passed, %0d failed, %0d errors", passedTests, failedTests,
                 errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : runaheadIssueTb

/* runaheadIssue.f */
+incdir+sim
src/runaheadPkg.sv
src/registerStatusTable.sv
src/forwardDetect.sv
src/operandValidation.sv
src/runaheadQueue.sv
src/runaheadIssue.sv
sim/runaheadIssueTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := runaheadIssueTb
FILELIST  := runaheadIssue.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Testbench passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
